/* Makefile */
# Verilator build and run of the CSR unit testbench
VERILATOR ?= verilator
SIM_TOP   ?= tb_csr_unit
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST  := csr_unit.f
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(SIM_TOP)

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

check:
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* csr_unit.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_port_if.sv
hdl/csr_irq_if.sv
hdl/csr_access.sv
hdl/csr_regfile.sv
hdl/csr_irq_ctrl.sv
hdl/csr_unit.sv
verification/csr_unit_assertions.sv
verification/tb_csr_unit.sv

/* hdl/csr_access.sv */
// CSR access front end with kill gating, write-mask lookup,
// write/set/clear merge and the read output
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_access
    import csr_pkg::*;
(
    input  wire logic      read_en_i,
    input  wire logic      write_en_i,
    input  wire logic      killed_i,
    input  wire csr_op_e   operation_i,
    input  wire csr_addr_t address_i,
    input  wire csr_word_t data_i,
    output csr_word_t      out_o,

    csr_port_if.access     port
);

    csr_word_t wmask;
    csr_word_t wbits;

    assign port.addr     = address_i;
    assign port.write_en = write_en_i & ~killed_i;

    //////////////////////////////////////////////////////////
    // Write mask per register
    //////////////////////////////////////////////////////////

    always_comb begin
        case (csr_addr_e'(address_i))
            CSR_MSTATUS:                wmask = `CSR_MASK_MSTATUS;
            CSR_MIE:                    wmask = `CSR_MASK_MIE;
            CSR_MTVEC, CSR_MEPC:        wmask = `CSR_MASK_ALIGN;
            CSR_MSCRATCH, CSR_MCAUSE,
            CSR_MTVAL:                  wmask = '1;
            CSR_MCYCLE, CSR_MCYCLEH,
            CSR_MINSTRET, CSR_MINSTRETH: wmask = '1;
            default:                    wmask = '0; // misa, mip, user aliases, IDs
        endcase
    end

    assign wbits = data_i & wmask;

    // Merge with the current contents
    always_comb begin
        case (operation_i)
            CSR_SET:   port.wr_data = port.rd_data | wbits;
            CSR_CLEAR: port.wr_data = port.rd_data & ~wbits;
            default:   port.wr_data = (port.rd_data & ~wmask) | wbits;
        endcase
    end

    assign out_o = (read_en_i && !killed_i) ? port.rd_data : '0;

endmodule

`default_nettype wire

/* hdl/csr_defs.svh */
// Widths, write masks, reset values and the misa constant
// for the machine-mode CSR unit
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data and address widths
`define CSR_XLEN   32
`define CSR_ADDR_W 12

// Write masks
`define CSR_MASK_MSTATUS 32'h0000_1888 // mpp, mpie, mie
`define CSR_MASK_MIE     32'h0000_0888 // meie, mtie, msie
`define CSR_MASK_ALIGN   32'hFFFF_FFFC // Word aligned mtvec and mepc

// MXL = 1 (RV32), U, M and I extensions
`define CSR_MISA_VALUE 32'h4010_1100

// Machine mode after reset
`define CSR_PRIV_RESET 2'b11

// Pc step used on interrupt entry
`define CSR_INSN_BYTES 32'd4

`endif

/* hdl/csr_irq_ctrl.sv */
// Interrupt sampling into mip, registered pending flag
// and cause selection
`timescale 1ns/1ps
`default_nettype none

module csr_irq_ctrl
    import csr_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire csr_word_t irq_i,
    input  wire logic      interrupt_ack_i,
    output logic           interrupt_pending_o,

    csr_irq_if.irq         irq
);

    csr_word_t mip_q;
    csr_word_t enabled;
    irq_code_e cause_sel;

    assign irq.mip = mip_q;
    assign enabled = irq.mie & mip_q;

    // External first, then software, then timer
    always_comb begin
        if (enabled[11])     cause_sel = IRQ_M_EXT;
        else if (enabled[3]) cause_sel = IRQ_M_SW;
        else                 cause_sel = IRQ_M_TIMER;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_q               <= '0;
            interrupt_pending_o <= 1'b0;
            irq.cause           <= IRQ_M_EXT;
        end else begin
            mip_q <= irq_i;
            if (irq.global_ie && (enabled != '0) && !interrupt_ack_i) begin
                interrupt_pending_o <= 1'b1;
                irq.cause           <= cause_sel;
            end else begin
                interrupt_pending_o <= 1'b0; // Also drops on ack
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_irq_if.sv */
// Interrupt enables, pending bits and cause between
// the interrupt controller and the register file
`timescale 1ns/1ps
`default_nettype none

interface csr_irq_if
    import csr_pkg::*;
;

    csr_word_t mie;
    logic      global_ie; // mstatus.mie
    csr_word_t mip;
    irq_code_e cause;

    modport regfile (
        output mie,
        output global_ie,
        input  mip,
        input  cause
    );

    modport irq (
        input  mie,
        input  global_ie,
        output mip,
        output cause
    );

endinterface

`default_nettype wire

/* hdl/csr_pkg.sv */
// Shared types of the CSR unit for data words, addresses,
// decoded CSR names, access operations, privilege and cause codes
`default_nettype none

`include "csr_defs.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]   csr_word_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Decoded CSR addresses without time and timeh
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        CSR_MCYCLEH   = 12'hB80,
        CSR_MINSTRETH = 12'hB82,
        CSR_CYCLE     = 12'hC00,
        CSR_INSTRET   = 12'hC02,
        CSR_CYCLEH    = 12'hC80,
        CSR_INSTRETH  = 12'hC82,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'd0,
        CSR_SET   = 2'd1,
        CSR_CLEAR = 2'd2
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_level_e;

    // Synchronous exception causes
    typedef enum logic [3:0] {
        EXC_INSN_MISALIGNED  = 4'd0,
        EXC_INSN_FAULT       = 4'd1,
        EXC_ILLEGAL_INSN     = 4'd2,
        EXC_BREAKPOINT       = 4'd3,
        EXC_LOAD_MISALIGNED  = 4'd4,
        EXC_LOAD_FAULT       = 4'd5,
        EXC_STORE_MISALIGNED = 4'd6,
        EXC_STORE_FAULT      = 4'd7,
        EXC_ECALL_U          = 4'd8,
        EXC_ECALL_M          = 4'd11
    } exc_code_e;

    typedef enum logic [3:0] {
        IRQ_M_SW    = 4'd3,
        IRQ_M_TIMER = 4'd7,
        IRQ_M_EXT   = 4'd11
    } irq_code_e;

endpackage

`default_nettype wire

/* hdl/csr_port_if.sv */
// Register access path between the access logic and the register file
`timescale 1ns/1ps
`default_nettype none

interface csr_port_if
    import csr_pkg::*;
;

    csr_addr_t addr;     // Raw CSR address
    logic      write_en; // Already gated by killed
    csr_word_t wr_data;  // Merged value under the write mask
    csr_word_t rd_data;  // Current register contents, combinational

    modport access (
        output addr,
        output write_en,
        output wr_data,
        input  rd_data
    );

    modport regfile (
        input  addr,
        input  write_en,
        input  wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

/* hdl/csr_regfile.sv */
// Machine CSRs, 64-bit cycle and instret counters,
// trap entry, machine return and the read multiplexer
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_regfile
    import csr_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire logic      killed_i,
    input  wire logic      hold_i,
    input  wire logic      raise_exception_i,
    input  wire exc_code_e exception_code_i,
    input  wire logic      machine_return_i,
    input  wire logic      interrupt_ack_i,
    input  wire csr_word_t pc_i,
    input  wire csr_word_t instruction_i,
    input  wire logic      jump_i,
    input  wire csr_word_t jump_target_i,
    output priv_level_e    privilege_o,
    output csr_word_t      mepc_o,
    output csr_word_t      mtvec_o,

    csr_port_if.regfile    port,
    csr_irq_if.regfile     irq
);

    csr_addr_e   addr_dec;
    logic        csr_we;
    logic        mstatus_mie;
    logic        mstatus_mpie;
    priv_level_e mstatus_mpp;
    priv_level_e privilege;
    csr_word_t   mstatus, mie, mtvec, mscratch, mepc, mcause, mtval;
    logic [63:0] mcycle, minstret;

    assign addr_dec = csr_addr_e'(port.addr);
    // Traps and return win over a CSR write in the same cycle
    assign csr_we   = port.write_en & ~(machine_return_i | raise_exception_i | interrupt_ack_i);

    assign mstatus = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};

    assign privilege_o   = privilege;
    assign mepc_o        = mepc;
    assign mtvec_o       = mtvec;
    assign irq.mie       = mie;
    assign irq.global_ie = mstatus_mie;

    //////////////////////////////////////////////////////////
    // Trap entry, return and CSR writes
    //////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_MACHINE;
            privilege    <= priv_level_e'(`CSR_PRIV_RESET);
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else if (machine_return_i) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= PRIV_USER;
            privilege    <= mstatus_mpp;
        end else if (raise_exception_i) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= privilege;
            privilege    <= PRIV_MACHINE;
            mepc         <= pc_i;
            mcause       <= {28'd0, exception_code_i};
            mtval        <= (exception_code_i == EXC_ILLEGAL_INSN) ? instruction_i : pc_i;
        end else if (interrupt_ack_i) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= privilege;
            privilege    <= PRIV_MACHINE;
            mcause       <= {1'b1, 27'd0, irq.cause};
            // Current instruction retires, so resume after it
            mepc         <= jump_i ? jump_target_i : pc_i + `CSR_INSN_BYTES;
        end else if (csr_we) begin
            case (addr_dec)
                CSR_MSTATUS: begin
                    mstatus_mpp  <= (port.wr_data[12:11] == 2'b11) ? PRIV_MACHINE : PRIV_USER;
                    mstatus_mpie <= port.wr_data[7];
                    mstatus_mie  <= port.wr_data[3];
                end
                CSR_MIE:      mie      <= port.wr_data;
                CSR_MTVEC:    mtvec    <= port.wr_data;
                CSR_MSCRATCH: mscratch <= port.wr_data;
                CSR_MEPC:     mepc     <= port.wr_data;
                CSR_MCAUSE:   mcause   <= port.wr_data;
                CSR_MTVAL:    mtval    <= port.wr_data;
                default: ;
            endcase
        end
    end

    // A counter write replaces the increment of that edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (!killed_i && !hold_i) begin
                minstret <= minstret + 64'd1;
            end
            if (csr_we) begin
                case (addr_dec)
                    CSR_MCYCLE:    mcycle   <= {mcycle[63:32], port.wr_data};
                    CSR_MCYCLEH:   mcycle   <= {port.wr_data, mcycle[31:0]};
                    CSR_MINSTRET:  minstret <= {minstret[63:32], port.wr_data};
                    CSR_MINSTRETH: minstret <= {port.wr_data, minstret[31:0]};
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////
    // Read multiplexer
    //////////////////////////////////////////////////////////

    always_comb begin
        case (addr_dec)
            CSR_MSTATUS:                 port.rd_data = mstatus;
            CSR_MISA:                    port.rd_data = `CSR_MISA_VALUE;
            CSR_MIE:                     port.rd_data = mie;
            CSR_MTVEC:                   port.rd_data = mtvec;
            CSR_MSCRATCH:                port.rd_data = mscratch;
            CSR_MEPC:                    port.rd_data = mepc;
            CSR_MCAUSE:                  port.rd_data = mcause;
            CSR_MTVAL:                   port.rd_data = mtval;
            CSR_MIP:                     port.rd_data = irq.mip;
            CSR_MCYCLE, CSR_CYCLE:       port.rd_data = mcycle[31:0];
            CSR_MCYCLEH, CSR_CYCLEH:     port.rd_data = mcycle[63:32];
            CSR_MINSTRET, CSR_INSTRET:   port.rd_data = minstret[31:0];
            CSR_MINSTRETH, CSR_INSTRETH: port.rd_data = minstret[63:32];
            CSR_MVENDORID, CSR_MARCHID,
            CSR_MIMPID, CSR_MHARTID:     port.rd_data = '0; // Not implemented IDs
            default:                     port.rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
// Machine-mode CSR unit top level
// Access front end, register file and interrupt controller
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit
    import csr_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire logic                 read_en_i,
    input  wire logic                 write_en_i,
    input  wire logic                 killed_i,
    input  wire logic                 hold_i,
    input  wire csr_op_e              operation_i,
    input  wire csr_addr_t            address_i,
    input  wire csr_word_t            data_i,
    output csr_word_t                 out_o,
    input  wire logic                 raise_exception_i,
    input  wire exc_code_e            exception_code_i,
    input  wire logic                 machine_return_i,
    input  wire logic                 interrupt_ack_i,
    input  wire csr_word_t            pc_i,
    input  wire csr_word_t            instruction_i,
    input  wire logic                 jump_i,
    input  wire csr_word_t            jump_target_i,
    input  wire logic [`CSR_XLEN-1:0] irq_i,
    output logic                      interrupt_pending_o,
    output priv_level_e               privilege_o,
    output csr_word_t                 mepc_o,
    output csr_word_t                 mtvec_o
);

    csr_port_if port_bus ();
    csr_irq_if  irq_bus ();

    csr_access i_csr_access (
        .read_en_i   (read_en_i),
        .write_en_i  (write_en_i),
        .killed_i    (killed_i),
        .operation_i (operation_i),
        .address_i   (address_i),
        .data_i      (data_i),
        .out_o       (out_o),
        .port        (port_bus.access)
    );

    csr_regfile i_csr_regfile (
        .clk               (clk),
        .reset_n           (reset_n),
        .killed_i          (killed_i),
        .hold_i            (hold_i),
        .raise_exception_i (raise_exception_i),
        .exception_code_i  (exception_code_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .pc_i              (pc_i),
        .instruction_i     (instruction_i),
        .jump_i            (jump_i),
        .jump_target_i     (jump_target_i),
        .privilege_o       (privilege_o),
        .mepc_o            (mepc_o),
        .mtvec_o           (mtvec_o),
        .port              (port_bus.regfile),
        .irq               (irq_bus.regfile)
    );

    csr_irq_ctrl i_csr_irq_ctrl (
        .clk                 (clk),
        .reset_n             (reset_n),
        .irq_i               (irq_i),
        .interrupt_ack_i     (interrupt_ack_i),
        .interrupt_pending_o (interrupt_pending_o),
        .irq                 (irq_bus.irq)
    );

endmodule

`default_nettype wire

/* verification/csr_unit_assertions.sv */
// Concurrent checks on the CSR unit top level
// Reset state, trap privilege, read gating and mtvec alignment
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assertions
    import csr_pkg::*;
(
    input wire logic        clk,
    input wire logic        reset_n,
    input wire logic        read_en_i,
    input wire logic        raise_exception_i,
    input wire logic        interrupt_pending_o,
    input wire priv_level_e privilege_o,
    input wire csr_word_t   out_o,
    input wire csr_word_t   mtvec_o
);

    // No pending interrupt while reset is held
    pending_low_in_reset: assert property (
        @(posedge clk) !reset_n |-> !interrupt_pending_o
    ) else $error("interrupt_pending_o high during reset");

    exception_enters_machine: assert property (
        @(posedge clk) disable iff (!reset_n)
        raise_exception_i |=> (privilege_o == PRIV_MACHINE)
    ) else $error("privilege_o not machine one cycle after an exception");

    read_gated_to_zero: assert property (
        @(posedge clk) disable iff (!reset_n)
        !read_en_i |-> (out_o == '0)
    ) else $error("out_o nonzero with read_en_i low");

    mtvec_word_aligned: assert property (
        @(posedge clk) disable iff (!reset_n)
        mtvec_o[1:0] == 2'b00 // Word aligned base
    ) else $error("mtvec_o low bits not zero");

endmodule

bind csr_unit csr_unit_assertions i_csr_unit_assertions (.*);

`default_nettype wire

/* verification/csr_unit_stim.txt */
# W op addr data rd killed exp_out   (op 0 write, 1 set, 2 clear; all fields hex)
# R addr exp_out | E code pc insn exp_mepc | M exp_priv | I irq pc jump target exp_mepc
W 0 340 deadbeef 1 0 00000000
R 340 deadbeef
W 1 340 0000000f 0 0 00000000
R 340 deadbeef
W 2 340 ffff0000 0 0 00000000
R 340 0000beef
W 0 340 12345678 1 1 00000000
R 340 0000beef
W 0 304 ffffffff 0 0 00000000
R 304 00000888
W 2 304 00000008 1 0 00000888
R 304 00000880
W 1 304 00000008 0 0 00000000
W 0 305 80000123 0 0 00000000
R 305 80000120
W 0 301 00000000 0 0 00000000
R 301 40101100
W 0 b00 00000100 0 0 00000000
R b00 00000100
R b00 00000101
W 0 300 00000000 0 0 00000000
M 0
E 2 00000100 ffffffff 00000100
R 342 00000002
R 343 ffffffff
M 0
E 8 00000200 00000073 00000200
R 343 00000200
W 1 300 00000008 0 0 00000000
I 00000880 00000300 0 00000000 00000304
R 342 8000000b
W 1 300 00000008 0 0 00000000
I 00000008 00000400 1 00001000 00001000
R 342 80000003

/* verification/tb_csr_unit.sv */
// Testbench for the CSR unit with clock, reset, stimulus file reader,
// compare tasks, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
;

    localparam int    CLK_PERIOD   = 10;
    localparam int    SAMPLE_DELAY = 2; // Into the low phase, after the drive
    localparam string STIM_FILE    = "verification/csr_unit_stim.txt";

    logic        clk;
    logic        reset_n;
    logic        read_en_i;
    logic        write_en_i;
    logic        killed_i;
    logic        hold_i;
    csr_op_e     operation_i;
    csr_addr_t   address_i;
    csr_word_t   data_i;
    csr_word_t   out_o;
    logic        raise_exception_i;
    exc_code_e   exception_code_i;
    logic        machine_return_i;
    logic        interrupt_ack_i;
    csr_word_t   pc_i;
    csr_word_t   instruction_i;
    logic        jump_i;
    csr_word_t   jump_target_i;
    csr_word_t   irq_i;
    logic        interrupt_pending_o;
    priv_level_e privilege_o;
    csr_word_t   mepc_o;
    csr_word_t   mtvec_o;

    int checks         = 0;
    int mismatches     = 0;
    int failures       = 0;
    int timeout_cycles = 0;

    csr_unit i_csr_unit (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog armed once the stimulus length is known
    initial begin
        wait (timeout_cycles != 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: stimulus did not finish within %0d cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input csr_word_t expected,
                              input csr_word_t actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_priv(input string name, input priv_level_e expected,
                              input priv_level_e actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %s, got %b", $time, name,
                     expected.name(), actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic report_bad_line(input logic [7:0] letter);
        failures++;
        $display("error: stimulus line for command %s is malformed", letter);
    endtask

    ////////////////////////////////////////////////////////////
    // Command tasks that start and end on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic release_strobes();
        read_en_i         = 1'b0;
        write_en_i        = 1'b0;
        killed_i          = 1'b0;
        raise_exception_i = 1'b0;
        machine_return_i  = 1'b0;
        interrupt_ack_i   = 1'b0;
        jump_i            = 1'b0;
    endtask

    task automatic access_csr(input csr_op_e op, input csr_addr_t addr, input csr_word_t data,
                              input logic rd, input logic kill, input csr_word_t exp_out);
        operation_i = op;
        address_i   = addr;
        data_i      = data;
        read_en_i   = rd;
        killed_i    = kill;
        write_en_i  = 1'b1;
        #SAMPLE_DELAY;
        check_word("out_o", exp_out, out_o); // Old contents before the write
        @(negedge clk);
        release_strobes();
    endtask

    task automatic read_csr(input csr_addr_t addr, input csr_word_t exp_out);
        address_i = addr;
        read_en_i = 1'b1;
        #SAMPLE_DELAY;
        check_word("out_o", exp_out, out_o);
        if (addr == CSR_MTVEC) begin
            check_word("mtvec_o", exp_out, mtvec_o);
        end
        @(negedge clk);
        release_strobes();
    endtask

    task automatic enter_exception(input exc_code_e code, input csr_word_t pc,
                                   input csr_word_t insn, input csr_word_t exp_mepc);
        exception_code_i  = code;
        pc_i              = pc;
        instruction_i     = insn;
        raise_exception_i = 1'b1;
        @(negedge clk);
        release_strobes();
        check_priv("privilege_o", PRIV_MACHINE, privilege_o);
        check_word("mepc_o", exp_mepc, mepc_o);
    endtask

    task automatic return_from_trap(input priv_level_e exp_priv);
        machine_return_i = 1'b1;
        @(negedge clk);
        release_strobes();
        check_priv("privilege_o", exp_priv, privilege_o);
    endtask

    task automatic serve_interrupt(input csr_word_t irq, input csr_word_t pc, input logic jmp,
                                   input csr_word_t target, input csr_word_t exp_mepc);
        int waited;
        waited = 0;
        irq_i  = irq;
        // One edge into mip, one more for the pending flag
        while (!interrupt_pending_o && waited < 2) begin
            @(negedge clk);
            waited++;
        end
        check_bit("interrupt_pending_o", 1'b1, interrupt_pending_o);
        pc_i            = pc;
        jump_i          = jmp;
        jump_target_i   = target;
        interrupt_ack_i = 1'b1;
        @(negedge clk);
        release_strobes();
        irq_i = '0;
        check_word("mepc_o", exp_mepc, mepc_o);
        check_priv("privilege_o", PRIV_MACHINE, privilege_o);
        check_bit("interrupt_pending_o", 1'b0, interrupt_pending_o);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int               fd;
        int               code;
        int               lines;
        logic [7:0]       cmd;
        logic [8*128-1:0] text;
        csr_word_t        a0, a1, a2, a3, a4, a5;

        release_strobes();
        reset_n          = 1'b1;
        hold_i           = 1'b0;
        operation_i      = CSR_WRITE;
        address_i        = '0;
        data_i           = '0;
        exception_code_i = EXC_INSN_MISALIGNED;
        pc_i             = '0;
        instruction_i    = '0;
        jump_target_i    = '0;
        irq_i            = '0;
        lines            = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            failures++;
            $display("error: stimulus file %s could not be opened", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                if (code != 0) lines++;
            end
            $fclose(fd);
            fd = $fopen(STIM_FILE, "r");
            timeout_cycles = lines * 20 + 100;

            #1 reset_n = 1'b0; // Real falling edge for the async reset
            repeat (3) @(negedge clk);
            reset_n = 1'b1;
            @(negedge clk);

            while ($fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "#": code = $fgets(text, fd); // Column header
                    "W": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h", a0, a1, a2, a3, a4, a5);
                        if (code == 6)
                            access_csr(csr_op_e'(a0[1:0]), a1[11:0], a2, a3[0], a4[0], a5);
                        else
                            report_bad_line(cmd);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", a0, a1);
                        if (code == 2) read_csr(a0[11:0], a1);
                        else report_bad_line(cmd);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
                        if (code == 4) enter_exception(exc_code_e'(a0[3:0]), a1, a2, a3);
                        else report_bad_line(cmd);
                    end
                    "M": begin
                        code = $fscanf(fd, "%h", a0);
                        if (code == 1) return_from_trap(priv_level_e'(a0[1:0]));
                        else report_bad_line(cmd);
                    end
                    "I": begin
                        code = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
                        if (code == 5) serve_interrupt(a0, a1, a2[0], a3, a4);
                        else report_bad_line(cmd);
                    end
                    default: report_bad_line(cmd);
                endcase
            end
            $fclose(fd);
        end

        $display("summary: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
